// File: compile.f
logic/oflow_pkg.sv
logic/oflow_div_seq.sv
logic/oflow_core_fsm_top.sv
logic/oflow_set_sequencer.sv
logic/oflow_conflict_resolve.sv
logic/oflow_mem_write.sv
logic/oflow_core_top.sv
test/oflow_tb.sv

// File: logic/oflow_conflict_resolve.sv
// conflict resolution stage: counts consecutive conflicting frames, aborts the sequence at threshold
`timescale 1ns/1ps
`default_nettype none

module oflow_conflict_resolve #(
	parameter int CONFLICT_TH = 3
) (
	input wire clk,
	input wire reset_N,
	input wire start_cr,
	input wire conflict_detected,
	output logic done_cr,
	output logic conflict_counter_th
);

	localparam int CNT_W = $clog2(CONFLICT_TH + 1);
	// count value one short of the threshold
	localparam logic [CNT_W-1:0] TH_LAST = CNT_W'(CONFLICT_TH - 1);

	logic pending;
	logic hit_q;
	logic [CNT_W-1:0] conflict_cnt;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			pending <= 1'b0;
			hit_q <= 1'b0;
			conflict_cnt <= '0;
			done_cr <= 1'b0;
			conflict_counter_th <= 1'b0;
		end else begin
			done_cr <= 1'b0;
			conflict_counter_th <= 1'b0;
			// stage 1, sample the PE comparison
			pending <= start_cr;
			if (start_cr) begin
				hit_q <= conflict_detected;
			end
			// stage 2, decide
			if (pending) begin
				if (!hit_q) begin
					// clean frame breaks the run
					conflict_cnt <= '0;
					done_cr <= 1'b1;
				end else if (conflict_cnt == TH_LAST) begin
					conflict_cnt <= '0;
					conflict_counter_th <= 1'b1;
				end else begin
					conflict_cnt <= conflict_cnt + 1'b1;
					done_cr <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/oflow_core_fsm_top.sv
// frame-level control FSM of the tracking core, steers divider, set sequencer, resolver and writer
`timescale 1ns/1ps
`default_nettype none

module oflow_core_fsm_top
	import oflow_pkg::*;
#(
	parameter int PE_NUM = 24
) (
	input wire clk,
	input wire reset_N,
	input wire start,
	input wire new_frame_from_dma,
	input wire bbox_count_t num_of_bbox_in_frame,
	input wire control_ready_new_set,
	input wire set_count_t counter_set_fe,
	input wire done_pe,
	input wire done_cr,
	input wire conflict_counter_th,
	input wire done_write,
	output logic ready_new_frame,
	output logic start_pe,
	output logic start_cr,
	output logic start_write_mem,
	output logic rnw_st,
	output logic valid_id,
	output frame_num_t frame_num,
	output bbox_count_t counter_of_remain_bboxes,
	output set_count_t num_of_sets,
	output pe_count_t num_of_bbox_in_last_set_div_4,
	output pe_count_t num_of_bbox_in_last_set_remainder_4
);

	localparam pe_count_t PE_NUM_DIV = pe_count_t'(PE_NUM);
	localparam bbox_count_t PE_NUM_BOX = bbox_count_t'(PE_NUM);

	// --------------------------------------------------------------------
	// declarations
	// --------------------------------------------------------------------

	core_state_t state_q;
	core_state_t state_d;

	logic start_div;
	logic div_complete;
	logic div_complete_d;
	// registered rising edge of div_complete
	logic div_rise;
	set_count_t quotient;
	set_count_t quo_q;
	pe_count_t remainder;
	pe_count_t rem_q;

	// --------------------------------------------------------------------
	// box count / PE_NUM
	// --------------------------------------------------------------------

	oflow_div_seq #(
		.A_WIDTH($bits(bbox_count_t)),
		.B_WIDTH($bits(pe_count_t))
	) div_seq (
		.clk(clk),
		.reset_N(reset_N),
		.start(start_div),
		.a(num_of_bbox_in_frame),
		.b(PE_NUM_DIV),
		.complete(div_complete),
		.quotient(quotient),
		.remainder(remainder)
	);

	// partial last set adds one more set
	assign num_of_sets = (rem_q != '0) ? quo_q + set_count_t'(1) : quo_q;
	assign num_of_bbox_in_last_set_div_4 = rem_q >> 2;
	assign num_of_bbox_in_last_set_remainder_4 = pe_count_t'(rem_q[1:0]);

	assign ready_new_frame = (state_q == idle_st);
	// memory reads everywhere except the write phase
	assign rnw_st = (state_q != write_st);

	// --------------------------------------------------------------------
	// state register and registered strobes
	// --------------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state_q <= idle_st;
			start_div <= 1'b0;
			div_complete_d <= 1'b0;
			div_rise <= 1'b0;
			valid_id <= 1'b0;
		end else begin
			state_q <= state_d;
			// divider kicked on the way into set_variables_st
			start_div <= (state_q == idle_st) && (state_d == set_variables_st);
			div_complete_d <= div_complete;
			div_rise <= div_complete && !div_complete_d;
			valid_id <= (state_q != write_st) && (state_d == write_st);
		end
	end

	// division results, held for the whole frame
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			quo_q <= '0;
			rem_q <= '0;
		end else if (state_q == set_variables_st && div_rise) begin
			quo_q <= quotient;
			rem_q <= remainder;
		end
	end

	// boxes not yet handed to the PE array
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			counter_of_remain_bboxes <= '0;
		end else if (state_q == set_variables_st) begin
			counter_of_remain_bboxes <= num_of_bbox_in_frame;
		end else if (state_q == pe_st && control_ready_new_set &&
				counter_of_remain_bboxes >= PE_NUM_BOX) begin
			counter_of_remain_bboxes <= counter_of_remain_bboxes - PE_NUM_BOX;
		end
	end

	// frame serial number, restarts on start or abort
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			frame_num <= '0;
		end else if ((state_q == idle_st && start) ||
				(state_q == conflict_resolve_st && conflict_counter_th)) begin
			frame_num <= '0;
		end else if (state_q == write_st && done_write) begin
			frame_num <= frame_num + frame_num_t'(1);
		end
	end

	// --------------------------------------------------------------------
	// next state and stage strobes
	// --------------------------------------------------------------------

	always_comb begin
		state_d = state_q;
		start_pe = 1'b0;
		start_cr = 1'b0;
		start_write_mem = 1'b0;
		case (state_q)
			idle_st: begin
				if (start || new_frame_from_dma) begin
					state_d = set_variables_st;
				end
			end
			set_variables_st: begin
				if (div_rise) begin
					start_pe = 1'b1;
					state_d = pe_st;
				end
			end
			pe_st: begin
				// all sets consumed by the PE array
				if (done_pe && counter_set_fe == num_of_sets) begin
					if (frame_num == '0) begin
						// first frame, nothing to resolve against
						start_write_mem = 1'b1;
						state_d = write_st;
					end else begin
						start_cr = 1'b1;
						state_d = conflict_resolve_st;
					end
				end
			end
			conflict_resolve_st: begin
				if (conflict_counter_th) begin
					state_d = idle_st;
				end else if (done_cr) begin
					start_write_mem = 1'b1;
					state_d = write_st;
				end
			end
			write_st: begin
				if (done_write) begin
					state_d = idle_st;
				end
			end
			default: begin
				state_d = idle_st;
			end
		endcase
	end

	a_start_pe_entry: assert property (@(posedge clk) disable iff (!reset_N)
		start_pe |-> (state_q == set_variables_st) ##1 (state_q == pe_st));

	// one write per frame, idle in between
	a_one_write: assert property (@(posedge clk) disable iff (!reset_N)
		start_write_mem |=> !start_write_mem until (state_q == idle_st));

endmodule

`default_nettype wire

// File: logic/oflow_core_top.sv
// top level of the frame control path, connects the FSM to the sequencer, resolver and writer
`timescale 1ns/1ps
`default_nettype none

module oflow_core_top
	import oflow_pkg::*;
#(
	parameter int PE_NUM = 24,
	parameter int CONFLICT_TH = 3,
	parameter int MAX_BBOX = 256
) (
	input wire clk,
	input wire reset_N,
	input wire start,
	input wire new_frame_from_dma,
	input wire new_set_from_dma,
	input wire bbox_count_t num_of_bbox_in_frame,
	input wire history_t num_of_history_frames,
	input wire conflict_detected,
	output logic ready_new_frame,
	output logic set_request,
	output frame_num_t frame_num,
	output set_count_t num_of_sets,
	output pe_count_t num_of_bbox_in_last_set_div_4,
	output pe_count_t num_of_bbox_in_last_set_remainder_4,
	output logic mem_rnw,
	output logic mem_we,
	output mem_addr_t mem_addr,
	output logic valid_id
);

	// --------------------------------------------------------------------
	// stage handshakes
	// --------------------------------------------------------------------

	logic start_pe;
	logic control_ready_new_set;
	logic done_pe;
	set_count_t counter_set_fe;
	logic start_cr;
	logic done_cr;
	logic conflict_counter_th;
	logic start_write_mem;
	logic done_write;

	oflow_core_fsm_top #(
		.PE_NUM(PE_NUM)
	) core_fsm (
		.clk(clk),
		.reset_N(reset_N),
		.start(start),
		.new_frame_from_dma(new_frame_from_dma),
		.num_of_bbox_in_frame(num_of_bbox_in_frame),
		.control_ready_new_set(control_ready_new_set),
		.counter_set_fe(counter_set_fe),
		.done_pe(done_pe),
		.done_cr(done_cr),
		.conflict_counter_th(conflict_counter_th),
		.done_write(done_write),
		.ready_new_frame(ready_new_frame),
		.start_pe(start_pe),
		.start_cr(start_cr),
		.start_write_mem(start_write_mem),
		.rnw_st(mem_rnw),
		.valid_id(valid_id),
		.frame_num(frame_num),
		// box countdown is for the PE array, outside this path
		.counter_of_remain_bboxes(),
		.num_of_sets(num_of_sets),
		.num_of_bbox_in_last_set_div_4(num_of_bbox_in_last_set_div_4),
		.num_of_bbox_in_last_set_remainder_4(num_of_bbox_in_last_set_remainder_4)
	);

	oflow_set_sequencer #(
		.PE_NUM(PE_NUM)
	) set_seq (
		.clk(clk),
		.reset_N(reset_N),
		.start_pe(start_pe),
		.new_set_from_dma(new_set_from_dma),
		.num_of_sets(num_of_sets),
		.num_of_bbox_in_last_set_div_4(num_of_bbox_in_last_set_div_4),
		.num_of_bbox_in_last_set_remainder_4(num_of_bbox_in_last_set_remainder_4),
		.set_request(set_request),
		.control_ready_new_set(control_ready_new_set),
		.done_pe(done_pe),
		.counter_set_fe(counter_set_fe)
	);

	oflow_conflict_resolve #(
		.CONFLICT_TH(CONFLICT_TH)
	) conflict_res (
		.clk(clk),
		.reset_N(reset_N),
		.start_cr(start_cr),
		.conflict_detected(conflict_detected),
		.done_cr(done_cr),
		.conflict_counter_th(conflict_counter_th)
	);

	oflow_mem_write #(
		.MAX_BBOX(MAX_BBOX)
	) mem_wr (
		.clk(clk),
		.reset_N(reset_N),
		.start_write_mem(start_write_mem),
		.frame_num(frame_num),
		.num_of_bbox_in_frame(num_of_bbox_in_frame),
		.num_of_history_frames(num_of_history_frames),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.done_write(done_write)
	);

endmodule

`default_nettype wire

// File: logic/oflow_div_seq.sv
// sequential restoring divider, one quotient bit per clock, used by the core FSM to split boxes into sets
`timescale 1ns/1ps
`default_nettype none

module oflow_div_seq
	import oflow_pkg::*;
#(
	parameter int A_WIDTH = 8,
	parameter int B_WIDTH = 5
) (
	input wire clk,
	input wire reset_N,
	input wire start,
	input wire bbox_count_t a,
	input wire pe_count_t b,
	output logic complete,
	output set_count_t quotient,
	output pe_count_t remainder
);

	localparam int CNT_W = $clog2(A_WIDTH);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(A_WIDTH - 1);

	logic busy;
	logic [CNT_W-1:0] bit_cnt;
	// dividend shifts out msb first, quotient bits shift in at lsb
	logic [A_WIDTH-1:0] quo_q;
	logic [B_WIDTH-1:0] rem_q;
	logic [B_WIDTH-1:0] divisor_q;
	// partial remainder with next dividend bit appended
	logic [B_WIDTH:0] partial;
	logic [B_WIDTH:0] diff;

	assign partial = {rem_q, quo_q[A_WIDTH-1]};
	assign diff = partial - {1'b0, divisor_q};

	assign quotient = set_count_t'(quo_q);
	assign remainder = rem_q;

	// bit counter and status
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
			complete <= 1'b0;
			bit_cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			complete <= 1'b0;
			bit_cnt <= '0;
		end else if (busy) begin
			if (bit_cnt == LAST_BIT) begin
				busy <= 1'b0;
				complete <= 1'b1;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// datapath, operands latched on start
	always_ff @(posedge clk) begin
		if (start) begin
			quo_q <= a;
			rem_q <= '0;
			divisor_q <= b;
		end else if (busy) begin
			// restore when the trial subtraction goes negative
			if (!diff[B_WIDTH]) begin
				rem_q <= diff[B_WIDTH-1:0];
				quo_q <= {quo_q[A_WIDTH-2:0], 1'b1};
			end else begin
				rem_q <= partial[B_WIDTH-1:0];
				quo_q <= {quo_q[A_WIDTH-2:0], 1'b0};
			end
		end
	end

	// a new operand pair only once the last one is done
	a_no_restart: assert property (@(posedge clk) disable iff (!reset_N)
		start |-> !busy);

endmodule

`default_nettype wire

// File: logic/oflow_mem_write.sv
// history memory writer: one entry per box into the current slot of the history frame ring
`timescale 1ns/1ps
`default_nettype none

module oflow_mem_write
	import oflow_pkg::*;
#(
	parameter int MAX_BBOX = 256
) (
	input wire clk,
	input wire reset_N,
	input wire start_write_mem,
	input wire frame_num_t frame_num,
	input wire bbox_count_t num_of_bbox_in_frame,
	input wire history_t num_of_history_frames,
	output logic mem_we,
	output mem_addr_t mem_addr,
	output logic done_write
);

	// slot stride in memory entries
	localparam mem_addr_t STRIDE = mem_addr_t'(MAX_BBOX);

	history_t slot_q;
	history_t slot_inc;
	bbox_count_t box_idx;

	assign slot_inc = slot_q + history_t'(1);
	assign mem_addr = mem_addr_t'(slot_q) * STRIDE + mem_addr_t'(box_idx);

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			slot_q <= '0;
			box_idx <= '0;
			mem_we <= 1'b0;
			done_write <= 1'b0;
		end else begin
			done_write <= 1'b0;
			if (start_write_mem) begin
				mem_we <= 1'b1;
				box_idx <= '0;
				// ring restarts with the frame count, else next slot mod history depth
				if (frame_num == '0 || slot_inc >= num_of_history_frames) begin
					slot_q <= '0;
				end else begin
					slot_q <= slot_inc;
				end
			end else if (mem_we) begin
				if (box_idx == num_of_bbox_in_frame - bbox_count_t'(1)) begin
					mem_we <= 1'b0;
					done_write <= 1'b1;
				end else begin
					box_idx <= box_idx + bbox_count_t'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/oflow_pkg.sv
// shared widths and FSM state encoding for the tracking core control path, imported by every stage
`default_nettype none

package oflow_pkg;

	// --------------------------------------------------------------------
	// vector widths with a meaning
	// --------------------------------------------------------------------

	// boxes in a frame, or boxes still to process
	typedef logic [7:0] bbox_count_t;
	// set count or set index
	typedef logic [4:0] set_count_t;
	// count inside one set of the PE array
	typedef logic [4:0] pe_count_t;
	// serial frame number since last restart
	typedef logic [7:0] frame_num_t;
	// history frame slots in the ring
	typedef logic [2:0] history_t;
	// history memory address, slot and box index
	typedef logic [10:0] mem_addr_t;

	// --------------------------------------------------------------------
	// core FSM
	// --------------------------------------------------------------------

	typedef enum logic [2:0] {
		idle_st,
		set_variables_st,
		pe_st,
		conflict_resolve_st,
		write_st
	} core_state_t;

endpackage

`default_nettype wire

// File: logic/oflow_set_sequencer.sv
// set sequencer: requests each set from the DMA and times the PE array, four boxes per PE cycle
`timescale 1ns/1ps
`default_nettype none

module oflow_set_sequencer
	import oflow_pkg::*;
#(
	parameter int PE_NUM = 24
) (
	input wire clk,
	input wire reset_N,
	input wire start_pe,
	input wire new_set_from_dma,
	input wire set_count_t num_of_sets,
	input wire pe_count_t num_of_bbox_in_last_set_div_4,
	input wire pe_count_t num_of_bbox_in_last_set_remainder_4,
	output logic set_request,
	output logic control_ready_new_set,
	output logic done_pe,
	output set_count_t counter_set_fe
);

	// PE cycles for a full set
	localparam pe_count_t FULL_SET_CYCLES = pe_count_t'(PE_NUM / 4);

	logic set_accept;
	logic pe_busy;
	pe_count_t pe_cnt;
	set_count_t next_set;
	pe_count_t last_set_cycles;
	pe_count_t set_cycles;

	// set pulses only count while requested
	assign set_accept = set_request && new_set_from_dma;
	assign next_set = counter_set_fe + set_count_t'(1);

	// ceil(remainder / 4), zero when the last set is full
	assign last_set_cycles = num_of_bbox_in_last_set_div_4 +
		pe_count_t'(num_of_bbox_in_last_set_remainder_4 != '0);
	assign set_cycles = (next_set == num_of_sets && last_set_cycles != '0) ?
		last_set_cycles : FULL_SET_CYCLES;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			set_request <= 1'b0;
			control_ready_new_set <= 1'b0;
			done_pe <= 1'b0;
			counter_set_fe <= '0;
			pe_busy <= 1'b0;
			pe_cnt <= '0;
		end else begin
			control_ready_new_set <= 1'b0;
			done_pe <= 1'b0;
			if (start_pe) begin
				// first request right after start
				counter_set_fe <= '0;
				set_request <= 1'b1;
				pe_busy <= 1'b0;
			end else if (set_accept) begin
				set_request <= 1'b0;
				counter_set_fe <= next_set;
				pe_busy <= 1'b1;
				pe_cnt <= set_cycles;
			end else if (pe_busy) begin
				if (pe_cnt == pe_count_t'(1)) begin
					pe_busy <= 1'b0;
					if (counter_set_fe == num_of_sets) begin
						done_pe <= 1'b1;
					end else begin
						// ask for the next set
						control_ready_new_set <= 1'b1;
						set_request <= 1'b1;
					end
				end else begin
					pe_cnt <= pe_cnt - pe_count_t'(1);
				end
			end
		end
	end

	a_done_after_last_set: assert property (@(posedge clk) disable iff (!reset_N)
		start_pe |=> !done_pe until (counter_set_fe == num_of_sets));

endmodule

`default_nettype wire

// File: test/oflow_tb.sv
// testbench for the tracking core control path, runs a scripted frame sequence against DMA and PE models
`timescale 1ns/1ps
`default_nettype none

module oflow_tb
	import oflow_pkg::*;
;

	localparam int PE_NUM = 24;
	localparam int CONFLICT_TH = 3;
	localparam int MAX_BBOX = 256;
	localparam int HISTORY = 3;
	localparam int NUM_FRAMES = 10;
	localparam int IDLE_TIMEOUT = 400;

	logic clk;
	logic reset_N;
	logic start;
	logic new_frame_from_dma;
	logic new_set_from_dma;
	bbox_count_t num_of_bbox_in_frame;
	history_t num_of_history_frames;
	logic conflict_detected;
	logic ready_new_frame;
	logic set_request;
	frame_num_t frame_num;
	set_count_t num_of_sets;
	pe_count_t num_of_bbox_in_last_set_div_4;
	pe_count_t num_of_bbox_in_last_set_remainder_4;
	logic mem_rnw;
	logic mem_we;
	mem_addr_t mem_addr;
	logic valid_id;

	integer seed = 32'h6a66ea4a;
	int errors = 0;
	int frames_issued = 0;
	int dma_delay = 0;
	bit timed_out = 1'b0;
	// reference state, kept by the stimulus between frames
	int ref_frame_num = 0;
	int ref_conf = 0;
	// per-frame counters taken from the DUT pins
	int frames_accepted;
	int sets_done;
	int wr_count;
	int valid_count;
	int total_writes;
	int lat;
	int exp_sets;
	int exp_div4;
	int exp_rem4;
	int exp_addr;
	int exp_lat;

	oflow_core_top #(
		.PE_NUM(PE_NUM),
		.CONFLICT_TH(CONFLICT_TH),
		.MAX_BBOX(MAX_BBOX)
	) DUT (
		.clk(clk),
		.reset_N(reset_N),
		.start(start),
		.new_frame_from_dma(new_frame_from_dma),
		.new_set_from_dma(new_set_from_dma),
		.num_of_bbox_in_frame(num_of_bbox_in_frame),
		.num_of_history_frames(num_of_history_frames),
		.conflict_detected(conflict_detected),
		.ready_new_frame(ready_new_frame),
		.set_request(set_request),
		.frame_num(frame_num),
		.num_of_sets(num_of_sets),
		.num_of_bbox_in_last_set_div_4(num_of_bbox_in_last_set_div_4),
		.num_of_bbox_in_last_set_remainder_4(num_of_bbox_in_last_set_remainder_4),
		.mem_rnw(mem_rnw),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.valid_id(valid_id)
	);

	// PE cycles of the final set, four boxes per cycle
	function automatic int last_set_cycles(input int boxes);
		int rem;
		rem = boxes % PE_NUM;
		if (rem == 0) begin
			return PE_NUM / 4;
		end
		return (rem + 3) / 4;
	endfunction

	task automatic report_mismatch(input string what, input int got, input int exp);
		errors++;
		$display("FAIL %s: got 0x%h, expected 0x%h", what, got, exp);
	endtask

	task automatic finish_run();
		$display("frames %0d, writes %0d, errors %0d", frames_issued, total_writes, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	// --------------------------------------------------------------------
	// expected values from the set and ring rules
	// --------------------------------------------------------------------

	assign exp_sets = (int'(num_of_bbox_in_frame) + PE_NUM - 1) / PE_NUM;
	assign exp_div4 = (int'(num_of_bbox_in_frame) % PE_NUM) / 4;
	assign exp_rem4 = (int'(num_of_bbox_in_frame) % PE_NUM) % 4;
	assign exp_addr = (ref_frame_num % HISTORY) * MAX_BBOX + wr_count;
	// resolver adds two cycles on later frames
	assign exp_lat = last_set_cycles(int'(num_of_bbox_in_frame)) + ((ref_frame_num == 0) ? 1 : 3);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// DMA model, answers each request after 0 to 3 cycles
	always @(negedge clk) begin
		new_set_from_dma = 1'b0;
		if (!set_request) begin
			dma_delay = {$random(seed)} % 4;
		end else if (dma_delay == 0) begin
			new_set_from_dma = 1'b1;
		end else begin
			dma_delay = dma_delay - 1;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			frames_accepted <= 0;
			sets_done <= 0;
			wr_count <= 0;
			valid_count <= 0;
			total_writes <= 0;
			lat <= 0;
		end else begin
			if (ready_new_frame && (start || new_frame_from_dma)) begin
				frames_accepted <= frames_accepted + 1;
				sets_done <= 0;
				wr_count <= 0;
				valid_count <= 0;
			end else begin
				if (set_request && new_set_from_dma) begin
					sets_done <= sets_done + 1;
				end
				if (mem_we) begin
					wr_count <= wr_count + 1;
				end
				if (valid_id) begin
					valid_count <= valid_count + 1;
				end
			end
			if (mem_we) begin
				total_writes <= total_writes + 1;
			end
			// cycles since the last honoured set
			lat <= (set_request && new_set_from_dma) ? 0 : lat + 1;
		end
	end

	// --------------------------------------------------------------------
	// concurrent checks
	// --------------------------------------------------------------------

	// reset values, seen on the first edge out of reset
	a_reset: assert property (@(posedge clk)
		$rose(reset_N) |-> ready_new_frame && !set_request && !mem_we && !valid_id)
		else report_mismatch("reset ready_new_frame,set_request,mem_we,valid_id",
			{$sampled(ready_new_frame), $sampled(set_request),
			$sampled(mem_we), $sampled(valid_id)}, 4'b1000);

	a_sets: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(set_request) |-> int'(num_of_sets) == exp_sets)
		else report_mismatch("num_of_sets", $sampled(num_of_sets), $sampled(exp_sets));

	a_div4: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(set_request) |-> int'(num_of_bbox_in_last_set_div_4) == exp_div4)
		else report_mismatch("num_of_bbox_in_last_set_div_4",
			$sampled(num_of_bbox_in_last_set_div_4), $sampled(exp_div4));

	a_rem4: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(set_request) |-> int'(num_of_bbox_in_last_set_remainder_4) == exp_rem4)
		else report_mismatch("num_of_bbox_in_last_set_remainder_4",
			$sampled(num_of_bbox_in_last_set_remainder_4), $sampled(exp_rem4));

	// no set beyond num_of_sets, all of them before the first write
	a_set_limit: assert property (@(posedge clk) disable iff (!reset_N)
		set_request && new_set_from_dma |-> sets_done < exp_sets)
		else report_mismatch("new_set_from_dma honoured count", $sampled(sets_done) + 1,
			$sampled(exp_sets));

	a_sets_before_write: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(mem_we) |-> sets_done == exp_sets)
		else report_mismatch("sets before mem_we", $sampled(sets_done), $sampled(exp_sets));

	a_write_latency: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(mem_we) |-> lat == exp_lat)
		else report_mismatch("mem_we latency after last set", $sampled(lat),
			$sampled(exp_lat));

	a_addr: assert property (@(posedge clk) disable iff (!reset_N)
		mem_we |-> int'(mem_addr) == exp_addr)
		else report_mismatch("mem_addr", $sampled(mem_addr), $sampled(exp_addr));

	a_write_len: assert property (@(posedge clk) disable iff (!reset_N)
		$fell(mem_we) |-> wr_count == int'(num_of_bbox_in_frame))
		else report_mismatch("mem_we run length", $sampled(wr_count),
			$sampled(num_of_bbox_in_frame));

	a_rnw: assert property (@(posedge clk) disable iff (!reset_N)
		mem_we |-> !mem_rnw)
		else report_mismatch("mem_rnw during write", $sampled(mem_rnw), 0);

	a_valid_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		valid_id |=> !valid_id)
		else report_mismatch("valid_id second cycle", 1, 0);

	// --------------------------------------------------------------------
	// frame sequence
	// --------------------------------------------------------------------

	task automatic wait_idle(input int frame_idx);
		int cycles;
		cycles = 0;
		while (!ready_new_frame && cycles < IDLE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!ready_new_frame) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: frame %0d never brought the FSM back to idle", frame_idx);
		end
	endtask

	task automatic run_frame(input int idx, input int boxes, input bit conflict);
		bit abort;
		abort = 1'b0;
		if (idx == 0) begin
			ref_frame_num = 0;
		end else if (ref_frame_num != 0) begin
			// resolver only sees later frames
			if (conflict) begin
				ref_conf++;
				if (ref_conf == CONFLICT_TH) begin
					abort = 1'b1;
					ref_conf = 0;
				end
			end else begin
				ref_conf = 0;
			end
		end
		@(negedge clk);
		num_of_bbox_in_frame = bbox_count_t'(boxes);
		conflict_detected = conflict;
		start = (idx == 0);
		new_frame_from_dma = (idx != 0);
		@(negedge clk);
		start = 1'b0;
		frames_issued++;
		// stray frame pulse while busy, must be ignored
		new_frame_from_dma = 1'b1;
		@(negedge clk);
		new_frame_from_dma = 1'b0;
		wait_idle(idx);
		if (timed_out) begin
			return;
		end
		ref_frame_num = abort ? 0 : ref_frame_num + 1;
		assert (wr_count == (abort ? 0 : boxes))
			else report_mismatch("mem_we count", wr_count, abort ? 0 : boxes);
		assert (valid_count == (abort ? 0 : 1))
			else report_mismatch("valid_id count", valid_count, abort ? 0 : 1);
		assert (sets_done == exp_sets)
			else report_mismatch("honoured set count", sets_done, exp_sets);
		assert (int'(frame_num) == ref_frame_num)
			else report_mismatch("frame_num", frame_num, ref_frame_num);
		assert (frames_accepted == frames_issued)
			else report_mismatch("accepted frame count", frames_accepted, frames_issued);
		repeat (2) @(negedge clk);
		assert (ready_new_frame)
			else report_mismatch("ready_new_frame after frame", ready_new_frame, 1);
	endtask

	initial begin
		// frame 0 opens with start, its conflict flag is unused
		bit conflict_script [NUM_FRAMES] = '{0, 0, 1, 0, 1, 1, 1, 1, 1, 0};
		int frame_boxes [NUM_FRAMES];
		// box counts drawn before the first clock edge
		for (int i = 0; i < NUM_FRAMES; i++) begin
			// full last set and single box cases forced
			if (i == 3) begin
				frame_boxes[i] = 48;
			end else if (i == 8) begin
				frame_boxes[i] = 1;
			end else begin
				frame_boxes[i] = {$random(seed)} % 60 + 1;
			end
		end
		reset_N = 1'b0;
		start = 1'b0;
		new_frame_from_dma = 1'b0;
		new_set_from_dma = 1'b0;
		num_of_bbox_in_frame = bbox_count_t'(1);
		num_of_history_frames = history_t'(HISTORY);
		conflict_detected = 1'b0;
		repeat (3) @(negedge clk);
		reset_N = 1'b1;
		for (int i = 0; i < NUM_FRAMES && !timed_out; i++) begin
			run_frame(i, frame_boxes[i], conflict_script[i]);
		end
		finish_run();
	end

endmodule

`default_nettype wire
